//--- Bender.yml
package:
  name: shared_alu

sources:
  - shared_alu_pkg.sv
  - leading_one_finder.sv
  - round_robin_arbiter.sv
  - op_decode.sv
  - alu_execute.sv
  - result_route.sv
  - shared_alu_top.sv
  - target: test
    files:
      - tb_shared_alu.sv

//--- alu_execute.sv
`timescale 1ns/100ps

module alu_execute (
    input  logic                     clk,
    input  logic                     rst_n,
    input  shared_alu_pkg::alu_dec_t dec,
    output shared_alu_pkg::alu_rsp_t res,
    output logic                     res_vld
);

    import shared_alu_pkg::*;

    // ============================================================
    // declarations
    // ============================================================

    // stage 1 payload, raw[DATA_W] holds carry, borrow or shift-out
    typedef struct packed {
        logic [CLIENT_ID_W-1:0] client;
        logic                   use_carry;
        logic [DATA_W:0]        raw;
    } s1_t;

    s1_t               s1_next;
    s1_t               s1_q;
    logic              s1_vld;
    logic [DATA_W-1:0] product;
    logic [DATA_W:0]   shifted;
    alu_rsp_t          rsp_next;

    // ============================================================
    // stage 1, raw result
    // ============================================================

    // low half of the product, upper half dropped
    assign product = dec.a * dec.b;

    // top bit ends up as the last bit shifted out
    assign shifted = {1'b0, dec.a} << dec.b[SHAMT_W-1:0];

    always_comb
    begin
        s1_next.client    = dec.client;
        s1_next.use_carry = dec.use_carry;
        if (dec.is_mul)
            s1_next.raw = {1'b0, product};
        else
        begin
            case (dec.op)
                OP_ADD:  s1_next.raw = {1'b0, dec.a} + {1'b0, dec.b};
                // wraps to 1 in the top bit on borrow
                OP_SUB:  s1_next.raw = {1'b0, dec.a} - {1'b0, dec.b};
                OP_AND:  s1_next.raw = {1'b0, dec.a & dec.b};
                OP_OR:   s1_next.raw = {1'b0, dec.a | dec.b};
                OP_XOR:  s1_next.raw = {1'b0, dec.a ^ dec.b};
                OP_SHL:  s1_next.raw = shifted;
                default: s1_next.raw = '0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            s1_vld <= 1'b0;
        else
            s1_vld <= dec.vld;
    end

    always_ff @(posedge clk)
    begin
        s1_q <= s1_next;
    end

    // ============================================================
    // stage 2, flags
    // ============================================================

    always_comb
    begin
        rsp_next.client = s1_q.client;
        rsp_next.result = s1_q.raw[DATA_W-1:0];
        rsp_next.zero   = (s1_q.raw[DATA_W-1:0] == '0);
        // logic ops and mul report no carry
        rsp_next.carry  = s1_q.use_carry & s1_q.raw[DATA_W];
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            res_vld <= 1'b0;
        else
            res_vld <= s1_vld;
    end

    always_ff @(posedge clk)
    begin
        res <= rsp_next;
    end

endmodule : alu_execute

//--- leading_one_finder.sv
`timescale 1ns/100ps

module leading_one_finder #(
    parameter int N = shared_alu_pkg::NUM_CLIENTS
) (
    input  logic [N-1:0]                           data,
    output logic [N-1:0]                           onehot,
    output logic [shared_alu_pkg::CLIENT_ID_W-1:0] index,
    output logic                                   valid
);

    import shared_alu_pkg::*;

    // ============================================================
    // priority scan, highest set bit wins
    // ============================================================

    always_comb
    begin
        onehot = '0;
        index  = '0;
        valid  = 1'b0;
        // walk upward, a later hit overrides an earlier one
        for (int i = 0; i < N; i++)
        begin
            if (data[i])
            begin
                onehot    = '0;
                onehot[i] = 1'b1;
                index     = i[CLIENT_ID_W-1:0];
                valid     = 1'b1;
            end
        end
    end

endmodule : leading_one_finder

//--- list.f
shared_alu_pkg.sv
leading_one_finder.sv
round_robin_arbiter.sv
op_decode.sv
alu_execute.sv
result_route.sv
shared_alu_top.sv
tb_shared_alu.sv

//--- op_decode.sv
`timescale 1ns/100ps

module op_decode (
    input  logic                                                  clk,
    input  logic                                                  rst_n,
    input  logic                                                  win,
    input  logic [shared_alu_pkg::CLIENT_ID_W-1:0]                win_client,
    input  shared_alu_pkg::alu_cmd_t [shared_alu_pkg::NUM_CLIENTS-1:0] cmd,
    output shared_alu_pkg::alu_dec_t                              dec
);

    import shared_alu_pkg::*;

    // ============================================================
    // declarations
    // ============================================================

    alu_cmd_t sel_cmd;
    alu_op_e  op_legal;
    alu_dec_t dec_next;
    // payload only, valid is kept apart
    alu_dec_t dec_q;
    logic     vld_q;

    // ============================================================
    // select and decode
    // ============================================================

    // command of this cycle's winner
    assign sel_cmd = cmd[win_client];

    // unused encoding falls back to add
    always_comb
    begin
        case (sel_cmd.op)
            OP_ADD, OP_SUB, OP_AND, OP_OR,
            OP_XOR, OP_SHL, OP_MUL: op_legal = sel_cmd.op;
            default:                op_legal = OP_ADD;
        endcase
    end

    always_comb
    begin
        dec_next.vld       = win;
        dec_next.client    = win_client;
        dec_next.op        = op_legal;
        dec_next.a         = sel_cmd.a;
        dec_next.b         = sel_cmd.b;
        // carry producers
        dec_next.use_carry = (op_legal == OP_ADD) || (op_legal == OP_SUB) ||
                             (op_legal == OP_SHL);
        dec_next.is_mul    = (op_legal == OP_MUL);
    end

    // ============================================================
    // capture, same edge as gnt
    // ============================================================

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            vld_q <= 1'b0;
        else
            vld_q <= dec_next.vld;
    end

    always_ff @(posedge clk)
    begin
        dec_q <= dec_next;
    end

    always_comb
    begin
        dec     = dec_q;
        dec.vld = vld_q;
    end

    // a decoded op never leaves the enum
    a_op_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        dec.vld |-> (dec.op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_MUL})
    );

endmodule : op_decode

//--- result_route.sv
`timescale 1ns/100ps

module result_route (
    input  logic                                                  clk,
    input  logic                                                  rst_n,
    input  shared_alu_pkg::alu_rsp_t                              res,
    input  logic                                                  res_vld,
    output logic [shared_alu_pkg::NUM_CLIENTS-1:0]                done,
    output shared_alu_pkg::alu_rsp_t [shared_alu_pkg::NUM_CLIENTS-1:0] rsp
);

    import shared_alu_pkg::*;

    // ============================================================
    // done pulse and held response per client
    // ============================================================

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            done <= '0;
            rsp  <= '0;
        end
        else
        begin
            // pulse lasts one cycle
            done <= '0;
            if (res_vld)
            begin
                done[res.client] <= 1'b1;
                // held until this client's next result
                rsp[res.client]  <= res;
            end
        end
    end

    a_done_onehot: assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0(done)
    );

endmodule : result_route

//--- round_robin_arbiter.sv
`timescale 1ns/100ps

module round_robin_arbiter (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic [shared_alu_pkg::NUM_CLIENTS-1:0] req,
    output logic [shared_alu_pkg::NUM_CLIENTS-1:0] gnt,
    output logic [shared_alu_pkg::CLIENT_ID_W-1:0] win_client,
    output logic                                   win
);

    import shared_alu_pkg::*;

    // ============================================================
    // declarations
    // ============================================================

    // previous winner, 0 out of reset
    logic [CLIENT_ID_W-1:0] last;
    // clients strictly below the previous winner
    logic [NUM_CLIENTS-1:0] mask;
    logic [NUM_CLIENTS-1:0] last_onehot;

    logic [NUM_CLIENTS-1:0] req_masked;
    logic [NUM_CLIENTS-1:0] req_wrap;

    logic [NUM_CLIENTS-1:0] masked_onehot;
    logic [CLIENT_ID_W-1:0] masked_index;
    logic                   masked_valid;

    logic [NUM_CLIENTS-1:0] wrap_onehot;
    logic [CLIENT_ID_W-1:0] wrap_index;
    logic                   wrap_valid;

    logic [NUM_CLIENTS-1:0] win_onehot;

    // ============================================================
    // request scans
    // ============================================================

    assign last_onehot = {{(NUM_CLIENTS-1){1'b0}}, 1'b1} << last;

    // below-last requests take priority
    assign req_masked = req & mask;

    // wrap scan skips last winner, unless it is the lone requester
    assign req_wrap = ($countones(req) > 1) ? (req & ~last_onehot) : req;

    leading_one_finder #(
        .N (NUM_CLIENTS)
    ) u_masked_finder (
        .data   (req_masked),
        .onehot (masked_onehot),
        .index  (masked_index),
        .valid  (masked_valid)
    );

    leading_one_finder #(
        .N (NUM_CLIENTS)
    ) u_wrap_finder (
        .data   (req_wrap),
        .onehot (wrap_onehot),
        .index  (wrap_index),
        .valid  (wrap_valid)
    );

    // ============================================================
    // winner select
    // ============================================================

    always_comb
    begin
        if (masked_valid)
        begin
            win_onehot = masked_onehot;
            win_client = masked_index;
        end
        else
        begin
            // start over from the top
            win_onehot = wrap_onehot;
            win_client = wrap_index;
        end
    end

    // wrap scan finds something whenever any req is up
    assign win = masked_valid | wrap_valid;

    // last, mask and gnt only move on a real win
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            last <= '0;
            mask <= '0;
            gnt  <= '0;
        end
        else
        begin
            gnt <= win ? win_onehot : '0;
            if (win)
            begin
                last <= win_client;
                mask <= win_onehot - 1'b1;
            end
        end
    end

    // ============================================================
    // checks
    // ============================================================

    a_gnt_onehot: assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0(gnt)
    );

    // grant goes to a client that requested at the deciding edge
    a_gnt_was_req: assert property (
        @(posedge clk) disable iff (!rst_n) (gnt & ~$past(req)) == '0
    );

endmodule : round_robin_arbiter

//--- shared_alu_pkg.sv
package shared_alu_pkg;

    // ============================================================
    // sizes
    // ============================================================

    // requesting clients and their index width
    localparam int NUM_CLIENTS = 4;
    localparam int CLIENT_ID_W = 2;

    // operand and result width
    localparam int DATA_W = 16;

    // shift count taken from the low bits of b
    localparam int SHAMT_W = 4;

    // ============================================================
    // opcodes
    // ============================================================

    // 3-bit encoding, 3'd7 unused
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_SHL = 3'd5,
        OP_MUL = 3'd6
    } alu_op_e;

    // ============================================================
    // command, decoded command, response
    // ============================================================

    // what a client drives alongside its req level
    typedef struct packed {
        alu_op_e           op;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
    } alu_cmd_t;

    // command in flight after decode
    typedef struct packed {
        logic                   vld;
        logic [CLIENT_ID_W-1:0] client;
        alu_op_e                op;
        logic [DATA_W-1:0]      a;
        logic [DATA_W-1:0]      b;
        // add, sub and shl report a carry
        logic                   use_carry;
        logic                   is_mul;
    } alu_dec_t;

    // finished result
    // carry is carry out, borrow or last bit shifted out
    typedef struct packed {
        logic [CLIENT_ID_W-1:0] client;
        logic [DATA_W-1:0]      result;
        logic                   zero;
        logic                   carry;
    } alu_rsp_t;

endpackage : shared_alu_pkg

//--- shared_alu_top.sv
`timescale 1ns/100ps

module shared_alu_top (
    input  logic                                                  clk,
    input  logic                                                  rst_n,
    input  logic [shared_alu_pkg::NUM_CLIENTS-1:0]                req,
    input  shared_alu_pkg::alu_cmd_t [shared_alu_pkg::NUM_CLIENTS-1:0] cmd,
    output logic [shared_alu_pkg::NUM_CLIENTS-1:0]                gnt,
    output logic [shared_alu_pkg::NUM_CLIENTS-1:0]                done,
    output shared_alu_pkg::alu_rsp_t [shared_alu_pkg::NUM_CLIENTS-1:0] rsp
);

    import shared_alu_pkg::*;

    // ============================================================
    // stage wiring
    // ============================================================

    // arbiter to decode, same cycle as the decision
    logic [CLIENT_ID_W-1:0] win_client;
    logic                   win;

    // decode to execute
    alu_dec_t dec;

    // execute to result stage
    alu_rsp_t res;
    logic     res_vld;

    round_robin_arbiter u_arbiter (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .gnt        (gnt),
        .win_client (win_client),
        .win        (win)
    );

    op_decode u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .win        (win),
        .win_client (win_client),
        .cmd        (cmd),
        .dec        (dec)
    );

    alu_execute u_execute (
        .clk     (clk),
        .rst_n   (rst_n),
        .dec     (dec),
        .res     (res),
        .res_vld (res_vld)
    );

    result_route u_route (
        .clk     (clk),
        .rst_n   (rst_n),
        .res     (res),
        .res_vld (res_vld),
        .done    (done),
        .rsp     (rsp)
    );

endmodule : shared_alu_top

//--- tb_shared_alu.sv
`timescale 1ns/100ps

module tb_shared_alu;

    import shared_alu_pkg::*;

    // ============================================================
    // run length
    // ============================================================

    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 8;
    localparam int ROTATE_CYCLES = 12;
    localparam int SINGLE_CYCLES = 8;
    localparam int RANDOM_CYCLES = 2000;
    localparam int DRAIN_CYCLES  = 6;
    localparam int TOTAL_CYCLES  = RESET_CYCLES + ROTATE_CYCLES + SINGLE_CYCLES +
                                   RANDOM_CYCLES + DRAIN_CYCLES;
    // extra cycles for results still in flight
    localparam int WATCHDOG_NS   = (TOTAL_CYCLES + 50) * CLK_PERIOD;
    localparam int SINGLE_CLIENT = 1;
    localparam logic [31:0] SEED = 32'h9e8130d3;

    typedef enum {MODE_ROT, MODE_SINGLE, MODE_RANDOM, MODE_DRAIN} tb_mode_e;

    logic                       clk;
    logic                       rst_n;
    logic [NUM_CLIENTS-1:0]     req;
    alu_cmd_t [NUM_CLIENTS-1:0] cmd;
    logic [NUM_CLIENTS-1:0]     gnt;
    logic [NUM_CLIENTS-1:0]     done;
    alu_rsp_t [NUM_CLIENTS-1:0] rsp;

    // model state
    int                     model_last;
    // gnt expected at the coming rising edge
    logic [NUM_CLIENTS-1:0] exp_gnt;
    // grants waiting out the 3-cycle latency
    logic [NUM_CLIENTS-1:0] done_pipe[$];
    alu_rsp_t               rsp_q[NUM_CLIENTS][$];
    alu_rsp_t               held[NUM_CLIENTS];
    int                     rot_next;
    int                     phase_cycle;
    int                     gnt_errors;
    int                     done_errors;
    int                     rsp_errors;

    shared_alu_top DUT (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .cmd   (cmd),
        .gnt   (gnt),
        .done  (done),
        .rsp   (rsp)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ============================================================
    // reference model
    // ============================================================

    // lone last winner keeps it, else highest below last, else highest other
    function automatic logic [NUM_CLIENTS-1:0] predict_gnt(
        input logic [NUM_CLIENTS-1:0] r,
        input int                     last
    );
        logic [NUM_CLIENTS-1:0] g;
        g = '0;
        if (r == '0)
            return g;
        if (r == (NUM_CLIENTS'(1) << last))
        begin
            g[last] = 1'b1;
            return g;
        end
        for (int i = last - 1; i >= 0; i--)
        begin
            if (r[i])
            begin
                g[i] = 1'b1;
                return g;
            end
        end
        for (int i = NUM_CLIENTS - 1; i >= 0; i--)
        begin
            if (i != last && r[i])
            begin
                g[i] = 1'b1;
                return g;
            end
        end
        return g;
    endfunction

    function automatic alu_rsp_t model_alu(input int client, input alu_cmd_t c);
        alu_rsp_t    r;
        logic [31:0] wide;
        int          sh;
        r.client = CLIENT_ID_W'(client);
        r.carry  = 1'b0;
        sh       = int'(c.b[3:0]);
        case (c.op)
            OP_SUB:
            begin
                r.result = c.a - c.b;
                r.carry  = (c.a < c.b);
            end
            OP_AND: r.result = c.a & c.b;
            OP_OR:  r.result = c.a | c.b;
            OP_XOR: r.result = c.a ^ c.b;
            OP_SHL:
            begin
                r.result = c.a << sh;
                // last bit pushed past the top
                if (sh > 0)
                    r.carry = c.a[DATA_W - sh];
            end
            OP_MUL:
            begin
                wide     = 32'(c.a) * 32'(c.b);
                r.result = wide[DATA_W-1:0];
            end
            // add, and the unused encoding that decodes to add
            default:
            begin
                wide     = 32'(c.a) + 32'(c.b);
                r.result = wide[DATA_W-1:0];
                r.carry  = wide[DATA_W];
            end
        endcase
        r.zero = (r.result == '0);
        return r;
    endfunction

    // any opcode incl. the unused one, b = a now and then for zero results
    function automatic alu_cmd_t random_cmd();
        alu_cmd_t c;
        c.op = alu_op_e'(3'($urandom_range(7, 0)));
        c.a  = DATA_W'($urandom);
        c.b  = DATA_W'($urandom);
        if ($urandom_range(3, 0) == 0)
            c.b = c.a;
        return c;
    endfunction

    function automatic bit results_pending();
        for (int c = 0; c < NUM_CLIENTS; c++)
        begin
            if (rsp_q[c].size() != 0)
                return 1'b1;
        end
        return 1'b0;
    endfunction

    // ============================================================
    // compare tasks
    // ============================================================

    task automatic check_gnt(input logic [NUM_CLIENTS-1:0] got, input logic [NUM_CLIENTS-1:0] exp);
        if (got !== exp)
        begin
            gnt_errors++;
            $display("ERR %0t: gnt is %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic check_done(input logic [NUM_CLIENTS-1:0] got, input logic [NUM_CLIENTS-1:0] exp);
        if (got !== exp)
        begin
            done_errors++;
            $display("ERR %0t: done is %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic check_rsp(input alu_rsp_t got, input alu_rsp_t exp, input int client);
        if (got !== exp)
        begin
            rsp_errors++;
            $display("ERR %0t: rsp[%0d] is c%0d r=%h z=%b cy=%b, expected c%0d r=%h z=%b cy=%b",
                     $time, client, got.client, got.result, got.zero, got.carry,
                     exp.client, exp.result, exp.zero, exp.carry);
        end
    endtask

    // ============================================================
    // one clock cycle, everything on the falling edge
    // ============================================================

    task automatic run_cycle(input tb_mode_e mode);
        logic [NUM_CLIENTS-1:0] seen_gnt;
        logic [NUM_CLIENTS-1:0] exp_d;
        @(negedge clk);
        seen_gnt = gnt;
        check_gnt(seen_gnt, exp_gnt);
        // fixed order 3, 2, 1, 0 with everyone requesting
        if (mode == MODE_ROT && phase_cycle > 0)
        begin
            check_gnt(seen_gnt, NUM_CLIENTS'(1) << rot_next);
            rot_next = (rot_next + NUM_CLIENTS - 1) % NUM_CLIENTS;
        end
        // lone requester is granted back to back
        if (mode == MODE_SINGLE && phase_cycle > 0)
            check_gnt(seen_gnt, NUM_CLIENTS'(1) << SINGLE_CLIENT);

        // done exactly 3 cycles after gnt
        exp_d = done_pipe.pop_front();
        check_done(done, exp_d);
        for (int c = 0; c < NUM_CLIENTS; c++)
        begin
            if (exp_d[c])
                held[c] = rsp_q[c].pop_front();
            // held value stays put between completions
            check_rsp(rsp[c], held[c], c);
        end
        done_pipe.push_back(exp_gnt);

        // new inputs, a granted client moves on
        for (int c = 0; c < NUM_CLIENTS; c++)
        begin
            case (mode)
                MODE_ROT:
                begin
                    req[c] = 1'b1;
                    if (seen_gnt[c])
                        cmd[c] = random_cmd();
                end
                MODE_SINGLE:
                begin
                    req[c] = (c == SINGLE_CLIENT);
                    if (seen_gnt[c])
                        cmd[c] = random_cmd();
                end
                MODE_RANDOM:
                begin
                    if (seen_gnt[c])
                        req[c] = 1'b0;
                    else if (!req[c] && $urandom_range(1, 0) == 1)
                    begin
                        req[c] = 1'b1;
                        cmd[c] = random_cmd();
                    end
                end
                default: req[c] = 1'b0;
            endcase
        end

        // predict the next decision from what was just driven
        exp_gnt = predict_gnt(req, model_last);
        for (int c = 0; c < NUM_CLIENTS; c++)
        begin
            if (exp_gnt[c])
            begin
                model_last = c;
                rsp_q[c].push_back(model_alu(c, cmd[c]));
            end
        end
        phase_cycle++;
    endtask

    // ============================================================
    // main sequence
    // ============================================================

    initial
    begin
        void'($urandom(SEED));
        $timeformat(-9, 0, " ns", 0);
        rst_n = 1'b0;
        req   = '0;
        for (int c = 0; c < NUM_CLIENTS; c++)
        begin
            cmd[c]  = random_cmd();
            held[c] = '0;
        end
        model_last  = 0;
        exp_gnt     = '0;
        done_pipe   = '{'0, '0, '0};
        rot_next    = NUM_CLIENTS - 1;
        gnt_errors  = 0;
        done_errors = 0;
        rsp_errors  = 0;

        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        phase_cycle = 0;
        repeat (ROTATE_CYCLES) run_cycle(MODE_ROT);
        phase_cycle = 0;
        repeat (SINGLE_CYCLES) run_cycle(MODE_SINGLE);
        phase_cycle = 0;
        repeat (RANDOM_CYCLES) run_cycle(MODE_RANDOM);
        // let the pipeline empty, then watch for stray done pulses
        while (results_pending())
            run_cycle(MODE_DRAIN);
        repeat (DRAIN_CYCLES) run_cycle(MODE_DRAIN);

        $display("errors: gnt %0d, done %0d, rsp %0d", gnt_errors, done_errors, rsp_errors);
        if (gnt_errors + done_errors + rsp_errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

    // watchdog
    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Verification failed");
        $finish;
    end

endmodule : tb_shared_alu
